// File: design/pf_pkg.sv
/*
 * shared widths, address and instruction word types, fetch FSM states
 * and the address source select used by the prefetch buffer
 */

package pf_pkg;

  // instruction addresses and fetched words are both one 32-bit word
  parameter int unsigned ADDR_WIDTH  = 32;
  parameter int unsigned INSTR_WIDTH = 32;

  // bytes per fetched word set both the sequential step and the alignment
  parameter int unsigned WORD_BYTES = 4;

  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [INSTR_WIDTH-1:0] instr_t;

  // fetch FSM states, the aborted state drops one stale response
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_GNT,
    ST_WAIT_RVALID,
    ST_ABORTED,
    ST_WAIT_JUMP
  } fetch_state_e;

  // source of the address put on the memory bus in the current cycle
  typedef enum logic [1:0] {
    ADDR_REG,
    ADDR_SEQ,
    ADDR_BRANCH
  } addr_sel_e;

endpackage

// File: design/pf_buf_if.sv
/*
 * handshake bundle between the fetch FSM and the instruction FIFO
 */

`timescale 1ns/1ps

interface pf_buf_if;

  // the controller tells the FIFO what to do with the current response
  logic push;
  logic flush;
  logic discard;

  // the FIFO reports its fill state back to the controller
  logic has_data;
  logic has_room;

  modport ctrl (
    output push,
    output flush,
    output discard,
    input  has_data,
    input  has_room
  );

  // FIFO side of the bundle
  modport buff (
    input  push,
    input  flush,
    input  discard,
    output has_data,
    output has_room
  );

endinterface

// File: design/pf_addr_gen.sv
/*
 * fetch address register with word-aligned sequential step and branch select
 */

`timescale 1ns/1ps

module pf_addr_gen import pf_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      branch_i,
  input  addr_t     addr_i,
  input  addr_sel_e addr_sel_i,
  input  logic      addr_upd_i,
  output addr_t     instr_addr_o
);

  // low address bits that lie inside one fetched word
  localparam addr_t WORD_MASK = addr_t'(WORD_BYTES - 1);

  addr_t addr_q;
  addr_t seq_addr;

  // next word after the last issued address, rounded down to a word first
  assign seq_addr = (addr_q & ~WORD_MASK) + addr_t'(WORD_BYTES);

  // a branch overrides whatever the controller selected
  always_comb begin
    if (branch_i) begin
      instr_addr_o = addr_i;
    end else begin
      unique case (addr_sel_i)
        ADDR_REG:    instr_addr_o = addr_q;
        ADDR_SEQ:    instr_addr_o = seq_addr;
        ADDR_BRANCH: instr_addr_o = addr_i;
        default:     instr_addr_o = addr_q;
      endcase
    end
  end

  // the register keeps the address that was last put on the bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (addr_upd_i) begin
      addr_q <= instr_addr_o;
    end
  end

endmodule

// File: design/pf_instr_buffer.sv
/*
 * circular instruction FIFO with fill counter, memory bypass when empty
 * and valid/ready handshake toward the core
 */

`timescale 1ns/1ps

module pf_instr_buffer import pf_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic   clk,
  input  logic   rst_n,
  input  instr_t instr_rdata_i,
  input  logic   instr_rvalid_i,
  input  logic   ready_i,
  pf_buf_if.buff buf_buf,
  output logic   valid_o,
  output instr_t rdata_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

  instr_t           mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign buf_buf.has_data = (count_q != '0);

  // one slot stays free for the response of the request now in flight
  assign buf_buf.has_room = (count_q < CNT_W'(FIFO_DEPTH - 1));

  // flush wins over push and pop in the same cycle
  assign do_push = buf_buf.push & ~buf_buf.flush;
  assign do_pop  = buf_buf.has_data & ready_i & ~buf_buf.flush;

  ////////////////////////////////////////////////////////////////////////////
  // core side output
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (buf_buf.has_data) begin
      valid_o = 1'b1;
      rdata_o = mem_q[rd_ptr_q];
    end else begin
      // empty FIFO, the memory response goes straight to the core
      valid_o = instr_rvalid_i & ~buf_buf.discard;
      rdata_o = instr_rdata_i & {INSTR_WIDTH{instr_rvalid_i}};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= instr_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (buf_buf.flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // a push and a pop together leave the fill level unchanged
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: design/pf_fetch_ctrl.sv
/*
 * fetch FSM for the req/gnt/rvalid memory port, drives FIFO push and
 * flush, address select and update, fetch failure and busy status
 */

`timescale 1ns/1ps

module pf_fetch_ctrl import pf_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req_i,
  input  logic      branch_i,
  input  logic      ready_i,
  input  logic      instr_gnt_i,
  input  logic      instr_rvalid_i,
  input  logic      instr_err_pmp_i,
  pf_buf_if.ctrl    buf_ctrl,
  output logic      instr_req_o,
  output addr_sel_e addr_sel_o,
  output logic      addr_upd_o,
  output logic      fetch_failed_o,
  output logic      busy_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         launch;
  logic         keep_resp;

  ////////////////////////////////////////////////////////////////////////////
  // decisions shared by several states
  ////////////////////////////////////////////////////////////////////////////

  // a branch always starts a fetch, otherwise the core must ask for it and
  // the FIFO must be able to take the word that comes back
  assign launch = branch_i | (req_i & buf_ctrl.has_room);

  // a response is stored when older words sit ahead of it in the FIFO or
  // when the core cannot take it in this cycle
  assign keep_resp = buf_ctrl.has_data | ~ready_i;

  // buffered words belong to the old stream once a branch is seen
  assign buf_ctrl.flush = branch_i;

  // the response that ends the aborted state is stale and never reaches the core
  assign buf_ctrl.discard = (state_q == ST_ABORTED);

  assign busy_o = (state_q != ST_IDLE) | instr_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    instr_req_o    = 1'b0;
    addr_sel_o     = branch_i ? ADDR_BRANCH : ADDR_SEQ;
    addr_upd_o     = 1'b0;
    fetch_failed_o = 1'b0;
    buf_ctrl.push  = 1'b0;

    unique case (state_q)
      // nothing outstanding, the next word follows the last issued address
      ST_IDLE: begin
        if (launch) begin
          instr_req_o = 1'b1;
          addr_upd_o  = 1'b1;
          state_d     = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end
      end

      // request held on the bus, only a branch may change its address
      ST_WAIT_GNT: begin
        instr_req_o = 1'b1;
        addr_sel_o  = branch_i ? ADDR_BRANCH : ADDR_REG;
        addr_upd_o  = branch_i;
        if (instr_gnt_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end

      // granted, the next request goes out in the cycle its data returns
      ST_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          buf_ctrl.push = keep_resp;
          if (launch) begin
            instr_req_o = 1'b1;
            addr_upd_o  = 1'b1;
            state_d     = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (branch_i) begin
          // keep the target and wait for the old response to drain
          addr_upd_o = 1'b1;
          state_d    = ST_ABORTED;
        end
      end

      // the register holds the branch target, the bus is free after rvalid
      ST_ABORTED: begin
        addr_sel_o = branch_i ? ADDR_BRANCH : ADDR_REG;
        addr_upd_o = branch_i;
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end
      end

      // parked after a PMP fault until the core branches away
      ST_WAIT_JUMP: begin
        // the failure is only shown once the good words ahead of it are gone
        fetch_failed_o = ~buf_ctrl.has_data & ~branch_i;
        if (branch_i) begin
          instr_req_o = 1'b1;
          addr_upd_o  = 1'b1;
          state_d     = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase

    // a faulting request counts as never granted, whatever gnt says
    if (instr_req_o && instr_err_pmp_i) begin
      state_d = ST_WAIT_JUMP;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: design/prefetch_buffer.sv
/*
 * prefetch buffer top level, joins the fetch FSM, address generator and
 * instruction FIFO to the core and memory ports
 */

`timescale 1ns/1ps

module prefetch_buffer import pf_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic   clk,
  input  logic   rst_n,

  // core side
  input  logic   req_i,
  input  logic   branch_i,
  input  addr_t  addr_i,
  input  logic   ready_i,
  output logic   valid_o,
  output instr_t rdata_o,

  // instruction memory side
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  instr_t instr_rdata_i,
  input  logic   instr_rvalid_i,
  input  logic   instr_err_pmp_i,

  // status
  output logic   fetch_failed_o,
  output logic   busy_o
);

  addr_sel_e addr_sel;
  logic      addr_upd;

  // push, flush and fill state between the FSM and the FIFO
  pf_buf_if buf_if ();

  pf_fetch_ctrl fetch_ctrl_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .ready_i         (ready_i),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_err_pmp_i (instr_err_pmp_i),
    .buf_ctrl        (buf_if.ctrl),
    .instr_req_o     (instr_req_o),
    .addr_sel_o      (addr_sel),
    .addr_upd_o      (addr_upd),
    .fetch_failed_o  (fetch_failed_o),
    .busy_o          (busy_o)
  );

  pf_addr_gen addr_gen_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .branch_i     (branch_i),
    .addr_i       (addr_i),
    .addr_sel_i   (addr_sel),
    .addr_upd_i   (addr_upd),
    .instr_addr_o (instr_addr_o)
  );

  pf_instr_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) instr_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .ready_i        (ready_i),
    .buf_buf        (buf_if.buff),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o)
  );

endmodule

// File: verif/pf_checker.sv
/*
 * bound protocol assertions on the memory request and the core status outputs
 */

`timescale 1ns/1ps

module pf_checker import pf_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  branch_i,
  input logic  instr_req_i,
  input addr_t instr_addr_i,
  input logic  instr_gnt_i,
  input logic  instr_rvalid_i,
  input logic  instr_err_pmp_i,
  input logic  valid_i,
  input logic  fetch_failed_i,
  input logic  busy_i
);

  // number of failed assertions in this instance
  int fail_count = 0;

  // a granted request stays outstanding until its rvalid comes back
  logic resp_pending_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_pending_q <= 1'b0;
    end else if (instr_req_i && instr_gnt_i && !instr_err_pmp_i) begin
      resp_pending_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      resp_pending_q <= 1'b0;
    end
  end

  // a request without grant stays on the bus with the same address unless the core branches
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i && !instr_gnt_i && !instr_err_pmp_i
    |=> branch_i || (instr_req_i && $stable(instr_addr_i)))
    else begin
      $error("memory request dropped or changed before its grant");
      fail_count++;
    end

  // a parked fetcher never presents a word to the core
  fail_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !(fetch_failed_i && valid_i))
    else begin
      $error("valid_o and fetch_failed_o are high together");
      fail_count++;
    end

  // busy covers every cycle with a request on the bus or a response still owed
  req_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_i || resp_pending_q) |-> busy_i)
    else begin
      $error("busy_o is low while a request is on the bus or a response is outstanding");
      fail_count++;
    end

endmodule

// File: verif/pf_scoreboard.sv
/*
 * reference model of the expected fetch stream with checks on accepted
 * words, fetch failure, reset values and forward progress
 */

`timescale 1ns/1ps

module pf_scoreboard import pf_pkg::*; #(
  parameter instr_t MEM_KEY     = '0,
  parameter int     STALL_LIMIT = 100
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   branch_i,
  input  addr_t  addr_i,
  input  logic   ready_i,
  input  logic   valid_i,
  input  instr_t rdata_i,
  input  logic   mem_req_i,
  input  logic   fetch_failed_i,
  input  logic   busy_i,
  output int     errors_o,
  output int     words_o,
  output int     faults_o
);

  // address of the next word the core should accept
  addr_t exp_addr;
  logic  failed_q;
  int    idle_cycles;

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors_o++;
  endtask

  initial begin
    errors_o    = 0;
    words_o     = 0;
    faults_o    = 0;
    exp_addr    = '0;
    failed_q    = 1'b0;
    idle_cycles = 0;
  end

  // inputs change just after the rising edge, so the falling edge sees settled values
  always @(negedge clk) begin
    if (!rst_n) begin
      if (valid_i || fetch_failed_i || mem_req_i || busy_i) begin
        report_mismatch("an output is active during reset");
      end
    end else begin
      if (fetch_failed_i && valid_i) begin
        report_mismatch("valid_o is high while fetch_failed_o is high");
      end
      // the fetcher parks only on the first word inside the PMP window
      if (fetch_failed_i && (exp_addr[11:8] != 4'hf)) begin
        report_mismatch($sformatf("fetch_failed_o high at address %h", exp_addr));
      end
      if (failed_q && !branch_i && !fetch_failed_i) begin
        report_mismatch("fetch_failed_o fell without a branch");
      end
      if (fetch_failed_i && !failed_q) begin
        faults_o++;
      end
      // a handshake in a branch cycle is void and the stream restarts at the target
      if (branch_i) begin
        exp_addr    = addr_i;
        idle_cycles = 0;
      end else if (valid_i && ready_i) begin
        if (rdata_i !== (exp_addr ^ MEM_KEY)) begin
          report_mismatch($sformatf("word %h, expected %h for address %h",
                                    rdata_i, exp_addr ^ MEM_KEY, exp_addr));
        end
        exp_addr    = exp_addr + 32'd4;
        words_o++;
        idle_cycles = 0;
      end else if (fetch_failed_i) begin
        idle_cycles = 0;
      end else begin
        idle_cycles++;
        if (idle_cycles == STALL_LIMIT) begin
          $display("error at %0t: no word accepted for %0d cycles", $time, STALL_LIMIT);
          errors_o++;
        end
      end
      failed_q = fetch_failed_i;
    end
  end

endmodule

// File: verif/tb_prefetch.sv
/*
 * testbench top for the prefetch buffer with clock, reset, random core
 * driver, instruction memory model and the closing report
 */

`timescale 1ns/1ps

module tb_prefetch import pf_pkg::*; ();

  localparam int unsigned SEED        = 32'h771f1c1a;
  localparam instr_t      MEM_KEY     = 32'h5a3c_96e1;
  localparam int          RUN_CYCLES  = 20000;
  localparam int          DRAIN_LIMIT = 300;

  logic   clk;
  logic   rst_n;
  logic   req;
  logic   branch;
  addr_t  target;
  logic   ready;
  logic   valid;
  instr_t rdata;
  logic   mem_req;
  addr_t  mem_addr;
  logic   mem_gnt;
  instr_t mem_rdata;
  logic   mem_rvalid;
  logic   mem_err;
  logic   fetch_failed;
  logic   busy;

  logic   gnt_en;
  addr_t  resp_addr;
  int     resp_wait;
  int     stall_left;
  int     err_count;
  int     word_count;
  int     fault_count;
  int     total_errors;
  int     words_start;
  int     drain_cycles;
  bit     drain_timeout;

  // requests with address bits 11 to 8 all set hit the PMP and are never granted
  assign mem_err = mem_req && (mem_addr[11:8] == 4'hf);
  assign mem_gnt = gnt_en && mem_req && !mem_err;

  prefetch_buffer dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req),
    .branch_i        (branch),
    .addr_i          (target),
    .ready_i         (ready),
    .valid_o         (valid),
    .rdata_o         (rdata),
    .instr_req_o     (mem_req),
    .instr_addr_o    (mem_addr),
    .instr_gnt_i     (mem_gnt),
    .instr_rdata_i   (mem_rdata),
    .instr_rvalid_i  (mem_rvalid),
    .instr_err_pmp_i (mem_err),
    .fetch_failed_o  (fetch_failed),
    .busy_o          (busy)
  );

  pf_scoreboard #(
    .MEM_KEY (MEM_KEY)
  ) scoreboard_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch),
    .addr_i         (target),
    .ready_i        (ready),
    .valid_i        (valid),
    .rdata_i        (rdata),
    .mem_req_i      (mem_req),
    .fetch_failed_i (fetch_failed),
    .busy_i         (busy),
    .errors_o       (err_count),
    .words_o        (word_count),
    .faults_o       (fault_count)
  );

  bind prefetch_buffer pf_checker checker_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .instr_req_i     (instr_req_o),
    .instr_addr_i    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_err_pmp_i (instr_err_pmp_i),
    .valid_i         (valid_o),
    .fetch_failed_i  (fetch_failed_o),
    .busy_i          (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hard limit on simulated time in case the run itself stops advancing
  initial begin
    #((RUN_CYCLES + 2 * DRAIN_LIMIT + 100) * 10);
    $display("timeout: the run did not finish within its time limit");
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // core driver and memory model
  ////////////////////////////////////////////////////////////////////////////

  // some targets sit just below the PMP window or inside it
  function automatic addr_t pick_target();
    addr_t r;
    r = $urandom;
    case ($urandom % 8)
      0:       pick_target = {r[31:12], 12'hef0};
      1:       pick_target = {r[31:12], 4'hf, r[7:2], 2'b00};
      default: pick_target = {r[31:2], 2'b00};
    endcase
  endfunction

  // rvalid comes one to three cycles after the grant that was sampled last
  task automatic drive_memory();
    gnt_en     = ($urandom % 3) != 0;
    mem_rvalid = 1'b0;
    mem_rdata  = $urandom;
    if (resp_wait > 0) begin
      resp_wait = resp_wait - 1;
      if (resp_wait == 0) begin
        mem_rvalid = 1'b1;
        mem_rdata  = resp_addr ^ MEM_KEY;
      end
    end
  endtask

  task automatic sample_memory();
    if (mem_req && mem_gnt) begin
      resp_addr = mem_addr;
      resp_wait = 1 + ($urandom % 3);
    end
  endtask

  // quiet mode keeps the core ready and asking without branches
  task automatic drive_core(input bit quiet, input bit force_branch);
    branch = 1'b0;
    if (quiet) begin
      req   = 1'b1;
      ready = 1'b1;
    end else begin
      req = ($urandom % 8) != 0;
      if (stall_left > 0) begin
        stall_left = stall_left - 1;
        ready      = 1'b0;
      end else begin
        ready = 1'b1;
        if (($urandom % 8) == 0) begin
          stall_left = 1 + ($urandom % 12);
        end
      end
    end
    if (force_branch || (!quiet && (($urandom % 32) == 0))) begin
      branch = 1'b1;
      target = pick_target();
    end
  endtask

  task automatic run_cycle(input bit quiet, input bit force_branch);
    @(posedge clk);
    #1;
    drive_memory();
    drive_core(quiet, force_branch);
    @(negedge clk);
    sample_memory();
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    req           = 1'b0;
    branch        = 1'b0;
    target        = '0;
    ready         = 1'b0;
    gnt_en        = 1'b0;
    mem_rdata     = '0;
    mem_rvalid    = 1'b0;
    resp_addr     = '0;
    resp_wait     = 0;
    stall_left    = 0;
    drain_timeout = 1'b0;
    void'($urandom(SEED));
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_cycle(1'b0, 1'b1);
    for (int i = 0; i < RUN_CYCLES; i++) begin
      run_cycle(1'b0, 1'b0);
    end
    // with the core always ready the stream must deliver words or park on a fault
    words_start  = word_count;
    drain_cycles = 0;
    while (!fetch_failed && (word_count < words_start + 8) && !drain_timeout) begin
      run_cycle(1'b1, 1'b0);
      drain_cycles++;
      if (drain_cycles >= DRAIN_LIMIT) begin
        drain_timeout = 1'b1;
      end
    end
    if (drain_timeout) begin
      $display("timeout: no words and no fetch failure within %0d cycles", DRAIN_LIMIT);
    end
    if (fault_count == 0) begin
      $display("no PMP fault occurred during the run");
    end
    total_errors = err_count + dut_i.checker_i.fail_count;
    $display("done: %0d words, %0d fetch faults, %0d check errors, %0d assertion failures",
             word_count, fault_count, err_count, dut_i.checker_i.fail_count);
    if ((total_errors == 0) && !drain_timeout && (fault_count > 0)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: prefetch.f
design/pf_pkg.sv
design/pf_buf_if.sv
design/pf_addr_gen.sv
design/pf_instr_buffer.sv
design/pf_fetch_ctrl.sv
design/prefetch_buffer.sv
verif/pf_checker.sv
verif/pf_scoreboard.sv
verif/tb_prefetch.sv

// File: Bender.yml
package:
  name: prefetch

sources:
  # design sources in compile order
  - files:
      - design/pf_pkg.sv
      - design/pf_buf_if.sv
      - design/pf_addr_gen.sv
      - design/pf_instr_buffer.sv
      - design/pf_fetch_ctrl.sv
      - design/prefetch_buffer.sv

  # testbench sources
  - target: simulation
    files:
      - verif/pf_checker.sv
      - verif/pf_scoreboard.sv
      - verif/tb_prefetch.sv
